//--- bench/aggregatingPermutePipelineTb.sv
module aggregatingPermutePipelineTb;

    localparam int clkPeriod = 100;
    localparam int identityWords = 20;
    localparam int randomWords = 300;
    // words times beats per word times margin
    localparam int timeoutCycles = (randomWords + identityWords + 8) * 8 * 4;

    logic clk;
    logic rstN;
    permutePkg::botT top;
    permutePkg::botT bot;
    logic writeData;
    permutePkg::permuteMaskT validBotPermutes;
    logic batchDone;
    logic slowDownInput;
    logic grabResults;
    logic resultsAvailable;
    permutePkg::sumT pcoeffSum;
    permutePkg::countT pcoeffCount;

    integer seed = 9524;
    int mismatchErrors = 0;
    int otherErrors = 0;
    int batchTotal = 0;
    int popped = 0;
    int modelSum = 0;
    int modelCount = 0;
    logic consumerStall = 1'b0;
    string phaseName = "resetState";

    // expected results in batch order
    permutePkg::sumT expSumQ[$];
    permutePkg::countT expCountQ[$];
    string expNameQ[$];

    aggregatingPermutePipeline uut (
        .clk             (clk),
        .rstN            (rstN),
        .top             (top),
        .bot             (bot),
        .writeData       (writeData),
        .validBotPermutes(validBotPermutes),
        .batchDone       (batchDone),
        .slowDownInput   (slowDownInput),
        .grabResults     (grabResults),
        .resultsAvailable(resultsAvailable),
        .pcoeffSum       (pcoeffSum),
        .pcoeffCount     (pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic permutePkg::botT randomBot();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic int countBits(permutePkg::botT b);
        int n;
        n = 0;
        for (int i = 0; i < 128; i++) begin
            n += b[i];
        end
        return n;
    endfunction

    // output index (a,b,c) reads input index with the variables in the order of mask bit k
    function automatic permutePkg::botT reorderVariables(permutePkg::botT b, int k);
        permutePkg::botT p;
        logic [5:0] letters;
        logic [2:0] vals;
        logic [6:0] src;
        // two bits per letter, A = 0, B = 1, C = 2
        case (k)
            4: letters = {2'd0, 2'd2, 2'd1};
            3: letters = {2'd1, 2'd0, 2'd2};
            2: letters = {2'd1, 2'd2, 2'd0};
            1: letters = {2'd2, 2'd0, 2'd1};
            0: letters = {2'd2, 2'd1, 2'd0};
            default: letters = {2'd0, 2'd1, 2'd2};
        endcase
        for (int i = 0; i < 128; i++) begin
            vals = {i[4], i[5], i[6]};
            src = {vals[letters[5:4]], vals[letters[3:2]], vals[letters[1:0]], i[3:0]};
            p[i] = b[src];
        end
        return p;
    endfunction

    task automatic modelWord(permutePkg::botT b, permutePkg::permuteMaskT m, logic done);
        permutePkg::botT p;
        for (int k = 5; k >= 0; k--) begin
            if (m[k]) begin
                p = reorderVariables(b, k);
                if ((p & ~top) == '0) begin
                    modelSum += countBits(top & ~p);
                    modelCount++;
                end
            end
        end
        if (done) begin
            expSumQ.push_back(permutePkg::sumT'(modelSum));
            expCountQ.push_back(permutePkg::countT'(modelCount));
            expNameQ.push_back(phaseName);
            batchTotal++;
            modelSum = 0;
            modelCount = 0;
        end
    endtask

    // holds off while the DUT asks the producer to slow down
    task automatic sendWord(permutePkg::botT b, permutePkg::permuteMaskT m, logic done);
        @(posedge clk);
        while (slowDownInput) begin
            writeData <= 1'b0;
            @(posedge clk);
        end
        bot <= b;
        validBotPermutes <= m;
        batchDone <= done;
        writeData <= 1'b1;
        modelWord(b, m, done);
    endtask

    task automatic drainResults();
        @(posedge clk);
        writeData <= 1'b0;
        while (popped < batchTotal) begin
            @(posedge clk);
        end
    endtask

    task automatic checkResult(permutePkg::sumT gotSum, permutePkg::countT gotCount);
        permutePkg::sumT expSum;
        permutePkg::countT expCount;
        string name;
        popped++;
        if (expSumQ.size() == 0) begin
            otherErrors++;
            $display("a result was popped while no batch was outstanding");
        end else begin
            expSum = expSumQ.pop_front();
            expCount = expCountQ.pop_front();
            name = expNameQ.pop_front();
            assert (gotSum == expSum) else begin
                mismatchErrors++;
                $display("Mismatch %s sum expected %0d actual %0d", name, expSum, gotSum);
            end
            assert (gotCount == expCount) else begin
                mismatchErrors++;
                $display("Mismatch %s count expected %0d actual %0d", name, expCount,
                    gotCount);
            end
        end
    endtask

    // consumer pops about 60% of the cycles unless stalled
    always @(posedge clk) begin
        if (rstN) begin
            if (grabResults && resultsAvailable) begin
                checkResult(pcoeffSum, pcoeffCount);
            end
            if (consumerStall) begin
                grabResults <= 1'b0;
            end else begin
                grabResults <= ({$random(seed)} % 10) < 6;
            end
        end
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        otherErrors++;
        $display("timeout: the pipeline did not deliver all results in time");
        $display("errors: %0d mismatches, %0d other", mismatchErrors, otherErrors);
        $display("tests failed");
        $finish;
    end

    initial begin
        permutePkg::botT b;
        logic done;
        rstN = 1'b0;
        top = '1;
        bot = '0;
        writeData = 1'b0;
        validBotPermutes = '0;
        batchDone = 1'b0;
        grabResults = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        repeat (2) @(posedge clk);
        assert (!resultsAvailable) else begin
            mismatchErrors++;
            $display("Mismatch %s resultsAvailable expected 0 actual %0b", phaseName,
                resultsAvailable);
        end
        assert (!slowDownInput) else begin
            mismatchErrors++;
            $display("Mismatch %s slowDownInput expected 0 actual %0b", phaseName,
                slowDownInput);
        end

        // top all ones, identity ordering only
        phaseName = "identityBatch";
        for (int i = 0; i < identityWords; i++) begin
            sendWord(randomBot(), 6'b100000, i == identityWords - 1);
        end
        drainResults();

        // empty word is dropped, marker alone closes an empty batch
        phaseName = "zeroMarker";
        sendWord(randomBot(), '0, 1'b0);
        sendWord(randomBot(), '0, 1'b1);
        drainResults();

        top <= randomBot() | randomBot();
        @(posedge clk);
        phaseName = "randomStalled";
        consumerStall = 1'b1;
        for (int i = 0; i < randomWords; i++) begin
            if (i == randomWords / 2) begin
                consumerStall = 1'b0;
                phaseName = "randomFlowing";
            end
            // sparse subsets of top give scoring hits, dense bots mostly miss
            if ({$random(seed)} % 3 == 0) begin
                b = randomBot();
            end else begin
                b = randomBot() & randomBot() & randomBot() & randomBot() & top;
            end
            done = ({$random(seed)} % 5 == 0) || (i == randomWords - 1);
            sendWord(b, permutePkg::permuteMaskT'($random(seed)), done);
        end
        drainResults();

        // nothing extra may show up afterwards
        repeat (20) @(posedge clk);
        assert (popped == batchTotal && !resultsAvailable) else begin
            otherErrors++;
            $display("result count is wrong: %0d popped for %0d batches", popped, batchTotal);
        end

        $display("errors: %0d mismatches, %0d other", mismatchErrors, otherErrors);
        if (mismatchErrors == 0 && otherErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- source/aggregatingPermutePipeline.sv
module aggregatingPermutePipeline #(
    parameter int inDepthLog2 = 5,
    parameter int outDepthLog2 = 9
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  permutePkg::botT         top,

    // producer side
    input  permutePkg::botT         bot,
    input  logic                    writeData,
    input  permutePkg::permuteMaskT validBotPermutes,
    input  logic                    batchDone,
    output logic                    slowDownInput,

    // consumer side
    input  logic                    grabResults,
    output logic                    resultsAvailable,
    output permutePkg::sumT         pcoeffSum,
    output permutePkg::countT       pcoeffCount
);

    localparam int inDepth = 1 << inDepthLog2;
    localparam int outDepth = 1 << outDepthLog2;

    logic inWrite;
    logic [permutePkg::inFifoWidth-1:0] inFifoOut;
    logic inEmpty;
    logic inAlmostFull;

    logic take;
    permutePkg::botT headBot;
    permutePkg::permuteMaskT headMask;
    logic headBatchDone;

    logic resultsAlmostFull;
    logic resultValid;
    permutePkg::sumT accSum;
    permutePkg::countT accCount;
    logic resultsEmpty;

    botStreamIf stream ();

    // words with nothing to permute and no batch end are dropped here
    assign inWrite = writeData && (|validBotPermutes || batchDone);
    assign {headBot, headMask, headBatchDone} = inFifoOut;

    // flag at more than depth minus eight words
    syncFifo #(
        .depthLog2      (inDepthLog2),
        .width          (permutePkg::inFifoWidth),
        .almostFullLevel(inDepth - 7)
    ) inputFifo (
        .clk        (clk),
        .rstN       (rstN),
        .writeEnable(inWrite),
        .dataIn     ({bot, validBotPermutes, batchDone}),
        .readEnable (take),
        .dataOut    (inFifoOut),
        .empty      (inEmpty),
        .usedw      (),
        .almostFull (inAlmostFull)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slowDownInput <= 1'b0;
        end else begin
            slowDownInput <= inAlmostFull;
        end
    end

    botPermuter permuter (
        .clk          (clk),
        .rstN         (rstN),
        .headBot      (headBot),
        .headMask     (headMask),
        .headBatchDone(headBatchDone),
        .headEmpty    (inEmpty),
        .take         (take),
        .out          (stream.source)
    );

    pcoeffAccumulator accumulator (
        .clk        (clk),
        .rstN       (rstN),
        .top        (top),
        .in         (stream.sink),
        .resultsFull(resultsAlmostFull),
        .resultValid(resultValid),
        .pcoeffSum  (accSum),
        .pcoeffCount(accCount)
    );

    // four slots held back for results still in the accumulator
    syncFifo #(
        .depthLog2      (outDepthLog2),
        .width          (permutePkg::resultWidth),
        .almostFullLevel(outDepth - 4)
    ) resultsFifo (
        .clk        (clk),
        .rstN       (rstN),
        .writeEnable(resultValid),
        .dataIn     ({accSum, accCount}),
        .readEnable (grabResults && resultsAvailable),
        .dataOut    ({pcoeffSum, pcoeffCount}),
        .empty      (resultsEmpty),
        .usedw      (),
        .almostFull (resultsAlmostFull)
    );

    assign resultsAvailable = !resultsEmpty;

endmodule

//--- source/botPermuter.sv
module botPermuter (
    input  logic                    clk,
    input  logic                    rstN,
    input  permutePkg::botT         headBot,
    input  permutePkg::permuteMaskT headMask,
    input  logic                    headBatchDone,
    input  logic                    headEmpty,
    output logic                    take,
    botStreamIf.source              out
);

    typedef enum logic {
        idle,
        emit
    } stateT;

    stateT state;

    // copy of the word being expanded
    permutePkg::botT botReg;
    permutePkg::permuteMaskT maskRem;
    logic batchDoneReg;

    // the word the next beat is built from
    permutePkg::botT srcBot;
    permutePkg::permuteMaskT srcMask;
    logic srcBatchDone;

    logic [2:0] sel;
    logic found;
    permutePkg::permuteMaskT restMask;
    logic beatDone;
    logic wordDone;

    assign out.valid = (state == emit);
    assign beatDone = out.valid && out.ready;
    // nothing left after the current beat
    assign wordDone = (maskRem == '0);
    assign take = !headEmpty && (state == idle || (beatDone && wordDone));

    always_comb begin
        srcBot = take ? headBot : botReg;
        srcMask = take ? headMask : maskRem;
        srcBatchDone = take ? headBatchDone : batchDoneReg;
        sel = 3'd0;
        found = 1'b0;
        // ascending scan, so the highest set bit wins
        for (int i = 0; i < 6; i++) begin
            if (srcMask[i]) begin
                sel = 3'(i);
                found = 1'b1;
            end
        end
        restMask = srcMask;
        if (found) begin
            restMask[sel] = 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take) begin
            botReg <= headBot;
        end
        if (take || (beatDone && !wordDone)) begin
            out.bot <= found ? permutePkg::permuteBot(srcBot, sel) : srcBot;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            maskRem <= '0;
            batchDoneReg <= 1'b0;
            out.counted <= 1'b0;
            out.last <= 1'b0;
        end else begin
            if (take) begin
                state <= emit;
                batchDoneReg <= headBatchDone;
                maskRem <= restMask;
                // zero mask gives a single marker beat
                out.counted <= found;
                out.last <= srcBatchDone && (restMask == '0);
            end else if (beatDone) begin
                if (wordDone) begin
                    state <= idle;
                end else begin
                    maskRem <= restMask;
                    out.counted <= found;
                    out.last <= srcBatchDone && (restMask == '0);
                end
            end
        end
    end

    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        out.valid && !out.ready |=> out.valid && $stable(out.bot)
            && $stable(out.counted) && $stable(out.last))
        else $error("botPermuter: beat changed while stalled");

endmodule

//--- source/botStreamIf.sv
// permuted bots from the permuter to the scoring pipeline
interface botStreamIf;
    logic valid;
    logic ready;
    permutePkg::botT bot;
    // low only on a batch marker beat
    logic counted;
    // final beat of a batch
    logic last;

    modport source (
        output valid,
        output bot,
        output counted,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  bot,
        input  counted,
        input  last,
        output ready
    );
endinterface

//--- source/pcoeffAccumulator.sv
module pcoeffAccumulator (
    input  logic                clk,
    input  logic                rstN,
    input  permutePkg::botT     top,
    botStreamIf.sink            in,
    input  logic                resultsFull,
    output logic                resultValid,
    output permutePkg::sumT     pcoeffSum,
    output permutePkg::countT   pcoeffCount
);

    logic beatTaken;

    // stage 1
    logic s1Valid;
    logic s1Subset;
    logic [7:0] s1Pop;
    logic s1Counted;
    logic s1Last;

    // stage 2 running totals
    permutePkg::sumT sumAcc;
    permutePkg::countT countAcc;
    logic addBeat;
    permutePkg::sumT nextSum;
    permutePkg::countT nextCount;

    // the results FIFO keeps four slots for beats still in flight
    assign in.ready = !resultsFull;
    assign beatTaken = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (beatTaken) begin
            // no bit of the bot outside top
            s1Subset <= ((in.bot & ~top) == '0);
            s1Pop <= 8'($countones(top & ~in.bot));
            s1Counted <= in.counted;
            s1Last <= in.last;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= beatTaken;
        end
    end

    always_comb begin
        addBeat = s1Valid && s1Counted && s1Subset;
        nextSum = sumAcc;
        nextCount = countAcc;
        if (addBeat) begin
            nextSum = sumAcc + permutePkg::sumT'(s1Pop);
            nextCount = countAcc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sumAcc <= '0;
            countAcc <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= s1Valid && s1Last;
            if (s1Valid && s1Last) begin
                // batch closes and the totals start over
                sumAcc <= '0;
                countAcc <= '0;
            end else begin
                sumAcc <= nextSum;
                countAcc <= nextCount;
            end
        end
    end

    // totals including the final beat
    always_ff @(posedge clk) begin
        if (s1Valid && s1Last) begin
            pcoeffSum <= nextSum;
            pcoeffCount <= nextCount;
        end
    end

    // the batch count must never wrap
    // the sum has room for a full count of popcounts
    totalsNoWrap: assert property (@(posedge clk) disable iff (!rstN)
        addBeat |-> countAcc != '1)
        else $error("pcoeffAccumulator: batch count overflow");

endmodule

//--- source/permutePkg.sv
package permutePkg;

    localparam int countWidth = 16;
    localparam int sumWidth = countWidth + 8;
    // bot, mask and batch-done flag
    localparam int inFifoWidth = 135;
    // sum and count
    localparam int resultWidth = 40;

    typedef logic [127:0] botT;
    typedef logic [5:0] permuteMaskT;
    typedef logic [countWidth-1:0] countT;
    typedef logic [sumWidth-1:0] sumT;

    // mask bit positions of the six orderings of A, B, C
    localparam int orderABC = 5;
    localparam int orderACB = 4;
    localparam int orderBAC = 3;
    localparam int orderBCA = 2;
    localparam int orderCAB = 1;
    localparam int orderCBA = 0;

    // output index (a,b,c) reads input index in the named ordering
    function automatic botT permuteBot(botT b, logic [2:0] order);
        botT p;
        logic [6:0] idx;
        logic [6:0] src;
        for (int i = 0; i < 128; i++) begin
            idx = 7'(i);
            case (order)
                3'(orderACB): src = {idx[6], idx[4], idx[5], idx[3:0]};
                3'(orderBAC): src = {idx[5], idx[6], idx[4], idx[3:0]};
                3'(orderBCA): src = {idx[5], idx[4], idx[6], idx[3:0]};
                3'(orderCAB): src = {idx[4], idx[6], idx[5], idx[3:0]};
                3'(orderCBA): src = {idx[4], idx[5], idx[6], idx[3:0]};
                default:      src = idx;
            endcase
            p[i] = b[src];
        end
        return p;
    endfunction

endpackage

//--- source/syncFifo.sv
module syncFifo #(
    parameter int depthLog2 = 5,
    parameter int width = 8,
    parameter int almostFullLevel = 28
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 writeEnable,
    input  logic [width-1:0]     dataIn,
    input  logic                 readEnable,
    output logic [width-1:0]     dataOut,
    output logic                 empty,
    output logic [depthLog2:0]   usedw,
    output logic                 almostFull
);

    localparam int depth = 1 << depthLog2;

    logic [width-1:0] mem [depth];
    logic [depthLog2-1:0] wrPtr;
    logic [depthLog2-1:0] rdPtr;
    logic full;

    assign empty = (usedw == '0);
    assign full = (usedw == (depthLog2 + 1)'(depth));
    assign almostFull = (usedw >= (depthLog2 + 1)'(almostFullLevel));
    // show-ahead head
    assign dataOut = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[wrPtr] <= dataIn;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            usedw <= '0;
        end else begin
            if (writeEnable) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (readEnable) begin
                rdPtr <= rdPtr + 1'b1;
            end
            if (writeEnable && !readEnable) begin
                usedw <= usedw + 1'b1;
            end else if (readEnable && !writeEnable) begin
                usedw <= usedw - 1'b1;
            end
        end
    end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        !(writeEnable && full))
        else $error("syncFifo: write while full");

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        !(readEnable && empty))
        else $error("syncFifo: read while empty");

endmodule

//--- src.f
source/permutePkg.sv
source/botStreamIf.sv
source/syncFifo.sv
source/botPermuter.sv
source/pcoeffAccumulator.sv
source/aggregatingPermutePipeline.sv
bench/aggregatingPermutePipelineTb.sv
